//--- logic/memPkg.sv
package memPkg;

    // access length of a data request
    // the encoded value is the byte count
    typedef enum logic [2:0] {
        ONE  = 3'd1,
        TWO  = 3'd2,
        FOUR = 3'd4
    } memLen_e;

    // transfer currently owning the RAM port
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        LOAD  = 2'd2,
        STORE = 2'd3
    } memKind_e;

    // one 32-bit word, seen whole or as four byte lanes
    // lane 0 is the lowest address, little-endian
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } memWord_u;

    // byte address width of the RAM
    parameter int MEM_ADDR_W_DEFAULT = 17;

endpackage

//--- logic/memCtrl.sv
`timescale 1ns/100ps

module memCtrl import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_rdy,
    input  logic     i_ioBufferFull,
    input  logic     i_fetchReq,
    input  logic     i_dataReq,
    input  logic     i_dataStore,
    input  memLen_e  i_dataLen,
    input  logic [1:0] i_beat,
    output logic     o_start,
    output logic     o_advance,
    output memKind_e o_kind,
    output logic     o_memWe,
    output logic     o_fetchDone,
    output logic     o_dataDone
);
    // phases inside a transfer
    localparam logic [1:0] PH_BEAT = 2'd0;
    localparam logic [1:0] PH_WAIT = 2'd1;
    localparam logic [1:0] PH_DONE = 2'd2;

    logic     frozen;
    logic     fetchPend;
    logic     dataPend;
    logic     dataPendStore;
    memLen_e  dataPendLen;
    memLen_e  curLen;
    memKind_e kind;
    memKind_e nextKind;
    logic [1:0] phase;
    logic     fetchAvail;
    logic     dataAvail;
    logic     dataStoreSel;
    memLen_e  lenSel;
    logic     lastBeat;
    logic     inBeat;

    assign frozen = !i_rdy || i_ioBufferFull;

    // a strobe in this cycle counts the same as a latched request
    assign fetchAvail   = fetchPend || i_fetchReq;
    assign dataAvail    = dataPend || i_dataReq;
    assign dataStoreSel = i_dataReq ? i_dataStore : dataPendStore;
    assign lenSel       = i_dataReq ? i_dataLen : dataPendLen;

    // data side wins over fetch
    assign nextKind = dataAvail ? (dataStoreSel ? STORE : LOAD) : FETCH;

    assign o_start = (kind == IDLE) && !frozen && (dataAvail || fetchAvail);

    // datapath sees the chosen kind already in the start cycle
    assign o_kind = o_start ? nextKind : kind;

    assign inBeat    = (kind != IDLE) && (phase == PH_BEAT);
    assign lastBeat  = ({1'b0, i_beat} + 3'd1) == curLen;
    assign o_advance = inBeat && !frozen;
    assign o_memWe   = inBeat && (kind == STORE) && !frozen;

    assign o_fetchDone = (kind == FETCH) && (phase == PH_DONE) && !frozen;
    assign o_dataDone  = ((kind == LOAD) || (kind == STORE)) && (phase == PH_DONE) && !frozen;

    always_ff @(posedge clk) begin
        if (rst) begin
            kind      <= IDLE;
            phase     <= PH_BEAT;
            fetchPend <= 1'b0;
            dataPend  <= 1'b0;
        end else begin
            // strobes are caught even while frozen
            if (i_fetchReq) begin
                fetchPend <= 1'b1;
            end
            if (i_dataReq) begin
                dataPend <= 1'b1;
            end

            if (!frozen) begin
                case (phase)
                    PH_BEAT: begin
                        if (kind != IDLE && lastBeat) begin
                            // stores have no data to wait for
                            phase <= (kind == STORE) ? PH_DONE : PH_WAIT;
                        end
                    end
                    PH_WAIT: begin
                        phase <= PH_DONE;
                    end
                    PH_DONE: begin
                        kind  <= IDLE;
                        phase <= PH_BEAT;
                    end
                    default: begin
                        phase <= PH_BEAT;
                    end
                endcase
            end

            if (o_start) begin
                kind  <= nextKind;
                phase <= PH_BEAT;
                if (dataAvail) begin
                    dataPend <= 1'b0;
                end else begin
                    fetchPend <= 1'b0;
                end
            end
        end
    end

    // request fields and transfer length
    always_ff @(posedge clk) begin
        if (i_dataReq) begin
            dataPendStore <= i_dataStore;
            dataPendLen   <= i_dataLen;
        end
        if (o_start) begin
            curLen <= dataAvail ? lenSel : FOUR;
        end
    end

    // one request per client until its done pulse
    assert property (@(posedge clk) disable iff (rst)
        i_fetchReq |-> !fetchPend && (kind != FETCH || o_fetchDone));
    assert property (@(posedge clk) disable iff (rst)
        i_dataReq |-> !dataPend && ((kind != LOAD && kind != STORE) || o_dataDone));

    // beat from the address generator stays inside the access
    assert property (@(posedge clk) disable iff (rst)
        inBeat |-> {1'b0, i_beat} < curLen);

endmodule

//--- logic/memAddrGen.sv
`timescale 1ns/100ps

module memAddrGen import memPkg::*; #(
    parameter int ADDR_W = MEM_ADDR_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  logic              i_advance,
    input  logic              i_fetchReq,
    input  logic              i_dataReq,
    input  logic [31:0]       i_fetchAddr,
    input  logic [31:0]       i_dataAddr,
    input  memKind_e          i_kind,
    output logic [ADDR_W-1:0] o_memAddr,
    output logic [1:0]        o_beat
);
    logic [ADDR_W-1:0] fetchHold;
    logic [ADDR_W-1:0] dataHold;
    logic [ADDR_W-1:0] fetchSel;
    logic [ADDR_W-1:0] dataSel;
    logic [ADDR_W-1:0] base;
    logic [1:0]        beat;

    // addresses are only valid in the strobe cycle, keep them for queued requests
    always_ff @(posedge clk) begin
        if (i_fetchReq) begin
            fetchHold <= i_fetchAddr[ADDR_W-1:0];
        end
        if (i_dataReq) begin
            dataHold <= i_dataAddr[ADDR_W-1:0];
        end
    end

    assign fetchSel = i_fetchReq ? i_fetchAddr[ADDR_W-1:0] : fetchHold;
    assign dataSel  = i_dataReq ? i_dataAddr[ADDR_W-1:0] : dataHold;

    always_ff @(posedge clk) begin
        if (i_start) begin
            base <= (i_kind == FETCH) ? fetchSel : dataSel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= 2'd0;
        end else if (i_start) begin
            beat <= 2'd0;
        end else if (i_advance) begin
            beat <= beat + 2'd1;
        end
    end

    assign o_beat    = beat;
    assign o_memAddr = (i_kind == IDLE) ? '0 : base + {{(ADDR_W-2){1'b0}}, beat};

    // consecutive beats hit consecutive bytes
    assert property (@(posedge clk) disable iff (rst)
        i_advance && beat != 2'd3 |=> o_memAddr == $past(o_memAddr) + 1'b1);

endmodule

//--- logic/memByteAssembler.sv
`timescale 1ns/100ps

module memByteAssembler import memPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_start,
    input  logic        i_advance,
    input  logic [1:0]  i_beat,
    input  logic [7:0]  i_memRd,
    output logic [31:0] o_word
);
    memWord_u   acc;
    logic [1:0] beatD;
    logic       advD;

    // RAM answers one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            advD <= 1'b0;
        end else begin
            advD <= i_advance;
        end
    end

    always_ff @(posedge clk) begin
        beatD <= i_beat;
    end

    // cleared on start so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (i_start) begin
            acc.word <= '0;
        end else if (advD) begin
            acc.bytes[beatD] <= i_memRd;
        end
    end

    assign o_word = acc.word;

endmodule

//--- logic/memStoreSerializer.sv
`timescale 1ns/100ps

module memStoreSerializer import memPkg::*; (
    input  logic        clk,
    input  logic        i_dataReq,
    input  logic [31:0] i_dataWr,
    input  logic [1:0]  i_beat,
    output logic [7:0]  o_memWr
);
    memWord_u storeWord;

    // taken at the strobe, the request may sit queued behind a fetch
    always_ff @(posedge clk) begin
        if (i_dataReq) begin
            storeWord.word <= i_dataWr;
        end
    end

    // little-endian, beat k carries byte lane k
    assign o_memWr = storeWord.bytes[i_beat];

endmodule

//--- logic/memSubsys.sv
`timescale 1ns/100ps

module memSubsys import memPkg::*; #(
    parameter int ADDR_W = MEM_ADDR_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              i_fetchReq,
    input  logic [31:0]       i_fetchAddr,
    output logic              o_fetchDone,
    output logic [31:0]       o_fetchInst,

    input  logic              i_dataReq,
    input  logic              i_dataStore,
    input  memLen_e           i_dataLen,
    input  logic [31:0]       i_dataAddr,
    input  logic [31:0]       i_dataWr,
    output logic              o_dataDone,
    output logic [31:0]       o_dataRd,

    input  logic              i_rdy,
    input  logic              i_ioBufferFull,

    output logic              o_memWe,
    output logic [ADDR_W-1:0] o_memAddr,
    output logic [7:0]        o_memWr,
    input  logic [7:0]        i_memRd
);
    logic        start;
    logic        advance;
    memKind_e    kind;
    logic [1:0]  beat;
    logic [31:0] readWord;

    memCtrl u_memCtrl (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetchReq     (i_fetchReq),
        .i_dataReq      (i_dataReq),
        .i_dataStore    (i_dataStore),
        .i_dataLen      (i_dataLen),
        .i_beat         (beat),
        .o_start        (start),
        .o_advance      (advance),
        .o_kind         (kind),
        .o_memWe        (o_memWe),
        .o_fetchDone    (o_fetchDone),
        .o_dataDone     (o_dataDone)
    );

    memAddrGen #(
        .ADDR_W (ADDR_W)
    ) u_memAddrGen (
        .clk         (clk),
        .rst         (rst),
        .i_start     (start),
        .i_advance   (advance),
        .i_fetchReq  (i_fetchReq),
        .i_dataReq   (i_dataReq),
        .i_fetchAddr (i_fetchAddr),
        .i_dataAddr  (i_dataAddr),
        .i_kind      (kind),
        .o_memAddr   (o_memAddr),
        .o_beat      (beat)
    );

    memByteAssembler u_memByteAssembler (
        .clk       (clk),
        .rst       (rst),
        .i_start   (start),
        .i_advance (advance),
        .i_beat    (beat),
        .i_memRd   (i_memRd),
        .o_word    (readWord)
    );

    memStoreSerializer u_memStoreSerializer (
        .clk       (clk),
        .i_dataReq (i_dataReq),
        .i_dataWr  (i_dataWr),
        .i_beat    (beat),
        .o_memWr   (o_memWr)
    );

    // one result word, each client reads it with its own done
    assign o_fetchInst = readWord;
    assign o_dataRd    = readWord;

endmodule

//--- bench/memSubsysTbRam.sv
`timescale 1ns/100ps

module memSubsysTbRam #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [7:0]        i_wr,
    output logic [7:0]        o_rd,
    output int                o_wrCount
);
    // preloaded by the testbench at time zero
    logic [7:0] mem [0:(1 << ADDR_W)-1];

    // registered read, data shows up one cycle after the address
    always @(posedge clk) begin
        o_rd <= mem[i_addr];
        if (i_we) begin
            mem[i_addr] <= i_wr;
        end
    end

    // write log, number of bytes written since reset
    always @(posedge clk) begin
        if (rst) begin
            o_wrCount <= 0;
        end else if (i_we) begin
            o_wrCount <= o_wrCount + 1;
        end
    end

endmodule

//--- bench/memSubsysTb.sv
`timescale 1ns/100ps

module memSubsysTb import memPkg::*; ();

    localparam int ADDR_W   = 12;
    localparam int MEM_SIZE = 1 << ADDR_W;
    localparam int TIMEOUT  = 200;

    logic              clk = 1'b0;
    logic              rst;
    logic              fetchReq;
    logic [31:0]       fetchAddr;
    logic              fetchDone;
    logic [31:0]       fetchInst;
    logic              dataReq;
    logic              dataStore;
    memLen_e           dataLen;
    logic [31:0]       dataAddr;
    logic [31:0]       dataWr;
    logic              dataDone;
    logic [31:0]       dataRd;
    logic              rdy;
    logic              ioBufferFull;
    logic              memWe;
    logic [ADDR_W-1:0] memAddr;
    logic [7:0]        memWr;
    logic [7:0]        memRd;
    logic              frozen;
    int                wrCount;

    // shadow of the RAM and the results still owed by the DUT
    logic [7:0]        shadow [0:MEM_SIZE-1];
    memWord_u          expFetchQ[$];
    memWord_u          expDataQ[$];
    bit                dataIsLoadQ[$];
    logic [ADDR_W-1:0] expWrAddrQ[$];
    logic [7:0]        expWrByteQ[$];

    int      cycle = 0;
    int      issueCycle = 0;
    int      fetchIssued = 0;
    int      dataIssued = 0;
    int      fetchDoneCount = 0;
    int      dataDoneCount = 0;
    int      fetchDoneCycle = 0;
    int      dataDoneCycle = 0;
    int      mainErrors = 0;
    int      cmpErrors = 0;
    int      tests = 0;
    int      pick;
    bit      timedOut = 1'b0;
    bit      freezeOn = 1'b0;
    memLen_e lens [3] = '{ONE, TWO, FOUR};

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    assign frozen = !rdy || ioBufferFull;

    memSubsys #(
        .ADDR_W (ADDR_W)
    ) u_memSubsys (
        .clk            (clk),
        .rst            (rst),
        .i_fetchReq     (fetchReq),
        .i_fetchAddr    (fetchAddr),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .i_dataReq      (dataReq),
        .i_dataStore    (dataStore),
        .i_dataLen      (dataLen),
        .i_dataAddr     (dataAddr),
        .i_dataWr       (dataWr),
        .o_dataDone     (dataDone),
        .o_dataRd       (dataRd),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .o_memWe        (memWe),
        .o_memAddr      (memAddr),
        .o_memWr        (memWr),
        .i_memRd        (memRd)
    );

    memSubsysTbRam #(
        .ADDR_W (ADDR_W)
    ) u_memSubsysTbRam (
        .clk       (clk),
        .rst       (rst),
        .i_we      (memWe),
        .i_addr    (memAddr),
        .i_wr      (memWr),
        .o_rd      (memRd),
        .o_wrCount (wrCount)
    );

    // little-endian, zero-extended word from the shadow
    function automatic memWord_u expectRead(input logic [ADDR_W-1:0] addr, input memLen_e len);
        memWord_u          w;
        logic [ADDR_W-1:0] a;
        w.word = 32'h0;
        for (int k = 0; k < int'(len); k++) begin
            a = addr + ADDR_W'(k);
            w.word = w.word | ({24'h0, shadow[a]} << (8 * k));
        end
        return w;
    endfunction

    function automatic int totalErrors();
        return mainErrors + cmpErrors;
    endfunction

    task automatic checkWord(input string name, input memWord_u got, input memWord_u exp);
        if (got.word !== exp.word) begin
            cmpErrors++;
            $display("Fail at %0.1f ns: %s got %h expected %h", $realtime, name, got.word,
                     exp.word);
        end
    endtask

    task automatic checkByte(input logic [ADDR_W-1:0] gotAddr, input logic [7:0] gotByte,
                             input logic [ADDR_W-1:0] expAddr, input logic [7:0] expByte);
        if (gotAddr !== expAddr) begin
            cmpErrors++;
            $display("Fail at %0.1f ns: o_memAddr got %h expected %h", $realtime, gotAddr,
                     expAddr);
        end
        if (gotByte !== expByte) begin
            cmpErrors++;
            $display("Fail at %0.1f ns: o_memWr got %h expected %h", $realtime, gotByte,
                     expByte);
        end
    endtask

    task automatic compareLatency(input string name, input int got, input int exp);
        if (got != exp) begin
            mainErrors++;
            $display("Fail at %0.1f ns: %s latency got %0d expected %0d", $realtime, name,
                     got, exp);
        end
    endtask

    // results and RAM writes, checked as they appear
    always @(negedge clk) begin : compareResults
        logic [ADDR_W-1:0] wa;
        logic [7:0]        wb;
        memWord_u          ew;
        bit                isLoad;
        if (!rst) begin
            if (memWe === 1'b1) begin
                if (frozen) begin
                    cmpErrors++;
                    $display("RAM write at %0.1f ns while the port is frozen", $realtime);
                end
                if (expWrAddrQ.size() == 0) begin
                    cmpErrors++;
                    $display("Unexpected RAM write at %0.1f ns to %h", $realtime, memAddr);
                end else begin
                    wa = expWrAddrQ.pop_front();
                    wb = expWrByteQ.pop_front();
                    checkByte(memAddr, memWr, wa, wb);
                end
            end
            if (fetchDone === 1'b1) begin
                if (frozen || expFetchQ.size() == 0) begin
                    cmpErrors++;
                    $display("Fetch done at %0.1f ns while frozen or unrequested", $realtime);
                end else begin
                    ew = expFetchQ.pop_front();
                    checkWord("o_fetchInst", memWord_u'(fetchInst), ew);
                end
                fetchDoneCount++;
                fetchDoneCycle = cycle;
            end
            if (dataDone === 1'b1) begin
                if (frozen || dataIsLoadQ.size() == 0) begin
                    cmpErrors++;
                    $display("Data done at %0.1f ns while frozen or unrequested", $realtime);
                end else begin
                    isLoad = dataIsLoadQ.pop_front();
                    if (isLoad) begin
                        ew = expDataQ.pop_front();
                        checkWord("o_dataRd", memWord_u'(dataRd), ew);
                    end
                end
                dataDoneCount++;
                dataDoneCycle = cycle;
            end
        end
    end

    // random freeze pattern while freezeOn is set
    initial begin
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        forever begin
            @(posedge clk);
            #0.5;
            pick = freezeOn ? int'($urandom % 4) : 0;
            rdy = (pick != 1);
            ioBufferFull = (pick == 2);
        end
    end

    // one strobe cycle, books what the DUT owes for it
    task automatic strobeRequests(input bit doFetch, input logic [ADDR_W-1:0] fa,
                                  input bit doData, input bit store, input memLen_e len,
                                  input logic [ADDR_W-1:0] da, input logic [31:0] wr);
        logic [ADDR_W-1:0] a;
        issueCycle = cycle;
        // data wins, so a fetch in the same cycle sees the stored bytes
        if (doData) begin
            dataReq   = 1'b1;
            dataStore = store;
            dataLen   = len;
            dataAddr  = {{(32-ADDR_W){1'b0}}, da};
            dataWr    = wr;
            dataIssued++;
            dataIsLoadQ.push_back(!store);
            if (store) begin
                for (int k = 0; k < int'(len); k++) begin
                    a = da + ADDR_W'(k);
                    expWrAddrQ.push_back(a);
                    expWrByteQ.push_back(wr[8*k +: 8]);
                    shadow[a] = wr[8*k +: 8];
                end
            end else begin
                expDataQ.push_back(expectRead(da, len));
            end
        end
        if (doFetch) begin
            fetchReq  = 1'b1;
            fetchAddr = {{(32-ADDR_W){1'b0}}, fa};
            fetchIssued++;
            expFetchQ.push_back(expectRead(fa, FOUR));
        end
        @(posedge clk);
        #0.5;
        fetchReq = 1'b0;
        dataReq  = 1'b0;
    endtask

    task automatic waitIdle(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while ((fetchDoneCount < fetchIssued || dataDoneCount < dataIssued) && n < TIMEOUT);
        #0.5;
        if (fetchDoneCount < fetchIssued || dataDoneCount < dataIssued) begin
            mainErrors++;
            timedOut = 1'b1;
            $display("Timeout: %s did not finish within %0d cycles", what, TIMEOUT);
        end
    endtask

    task automatic printTestLine(input string name, input int errBefore);
        tests++;
        $display("test %s finished with %0d errors", name, totalErrors() - errBefore);
    endtask

    task automatic checkResetQuiet();
        int errBefore;
        errBefore = totalErrors();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (fetchDone !== 1'b0 || dataDone !== 1'b0 || memWe !== 1'b0) begin
                mainErrors++;
                $display("Done or write strobe not low at %0.1f ns after reset", $realtime);
            end
        end
        @(posedge clk);
        #0.5;
        printTestLine("reset", errBefore);
    endtask

    task automatic fetchRandom();
        int errBefore;
        errBefore = totalErrors();
        for (int i = 0; i < 6; i++) begin
            strobeRequests(1'b1, ADDR_W'($urandom), 1'b0, 1'b0, FOUR, '0, '0);
            waitIdle("fetch");
            compareLatency("o_fetchDone", fetchDoneCycle - issueCycle, 6);
        end
        printTestLine("fetch", errBefore);
    endtask

    task automatic loadAllLengths();
        int errBefore;
        errBefore = totalErrors();
        for (int i = 0; i < 3; i++) begin
            for (int r = 0; r < 3; r++) begin
                strobeRequests(1'b0, '0, 1'b1, 1'b0, lens[i], ADDR_W'($urandom), '0);
                waitIdle("load");
                compareLatency("o_dataDone", dataDoneCycle - issueCycle, int'(lens[i]) + 2);
            end
        end
        printTestLine("load", errBefore);
    endtask

    task automatic storeAndReadBack();
        int                errBefore;
        int                wrBefore;
        logic [ADDR_W-1:0] a;
        errBefore = totalErrors();
        for (int i = 0; i < 3; i++) begin
            for (int r = 0; r < 2; r++) begin
                a = ADDR_W'($urandom);
                wrBefore = wrCount;
                strobeRequests(1'b0, '0, 1'b1, 1'b1, lens[i], a, $urandom);
                waitIdle("store");
                compareLatency("o_dataDone", dataDoneCycle - issueCycle, int'(lens[i]) + 1);
                if (wrCount - wrBefore != int'(lens[i])) begin
                    mainErrors++;
                    $display("RAM logged %0d writes for a %0d-byte store",
                             wrCount - wrBefore, int'(lens[i]));
                end
                // one byte below the store as well
                strobeRequests(1'b0, '0, 1'b1, 1'b0, FOUR, a - ADDR_W'(1), '0);
                waitIdle("load after store");
            end
        end
        printTestLine("store", errBefore);
    endtask

    task automatic raceFetchAndData(input string what);
        logic [ADDR_W-1:0] fa;
        logic [ADDR_W-1:0] da;
        logic [31:0]       wr;
        bit                store;
        memLen_e           len;
        fa = ADDR_W'($urandom);
        da = ADDR_W'($urandom);
        wr = $urandom;
        store = 1'($urandom);
        len = lens[$urandom % 3];
        strobeRequests(1'b1, fa, 1'b1, store, len, da, wr);
        waitIdle(what);
        if (dataDoneCycle >= fetchDoneCycle) begin
            mainErrors++;
            $display("%s: data done in cycle %0d not before fetch done in cycle %0d",
                     what, dataDoneCycle, fetchDoneCycle);
        end
    endtask

    task automatic contendFetchData();
        int errBefore;
        errBefore = totalErrors();
        for (int i = 0; i < 6; i++) begin
            raceFetchAndData("contention");
        end
        printTestLine("contention", errBefore);
    endtask

    task automatic freezeMidTransfer();
        int errBefore;
        errBefore = totalErrors();
        freezeOn = 1'b1;
        for (int i = 0; i < 10; i++) begin
            raceFetchAndData("freeze");
        end
        freezeOn = 1'b0;
        repeat (2) @(posedge clk);
        #0.5;
        printTestLine("freeze", errBefore);
    endtask

    initial begin
        void'($urandom(32'h7a3e635e));
        rst       = 1'b1;
        fetchReq  = 1'b0;
        fetchAddr = '0;
        dataReq   = 1'b0;
        dataStore = 1'b0;
        dataLen   = ONE;
        dataAddr  = '0;
        dataWr    = '0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            shadow[i] = 8'($urandom);
            u_memSubsysTbRam.mem[i] = shadow[i];
        end
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;

        checkResetQuiet();
        if (!timedOut) begin
            fetchRandom();
        end
        if (!timedOut) begin
            loadAllLengths();
        end
        if (!timedOut) begin
            storeAndReadBack();
        end
        if (!timedOut) begin
            contendFetchData();
        end
        if (!timedOut) begin
            freezeMidTransfer();
        end

        if (expFetchQ.size() != 0 || dataIsLoadQ.size() != 0 || expWrAddrQ.size() != 0) begin
            mainErrors++;
            $display("Results or RAM writes still missing at the end of the run");
        end
        $display("%0d tests run, %0d errors", tests, totalErrors());
        if (totalErrors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- memSubsys.f
logic/memPkg.sv
logic/memCtrl.sv
logic/memAddrGen.sv
logic/memByteAssembler.sv
logic/memStoreSerializer.sv
logic/memSubsys.sv
bench/memSubsysTbRam.sv
bench/memSubsysTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memSubsys testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module memSubsysTb \
    -f memSubsys.f -o memSubsysSim \
    && ./obj_dir/memSubsysSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
